//--- hw/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// operation codes
`define CSR_OP_EXCEPTION 3'd0
`define CSR_OP_MRET 3'd1
`define CSR_OP_NOP 3'd3
`define CSR_OP_RW 3'd5
`define CSR_OP_RS 3'd6
`define CSR_OP_RC 3'd7

// machine csr addresses
`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MIE 12'h304
`define CSR_ADDR_MEPC 12'h341
`define CSR_ADDR_MCAUSE 12'h342
`define CSR_ADDR_MIP 12'h344

// bit positions inside the csr words
`define CSR_BIT_IE 3 // mstatus
`define CSR_BIT_PIE 7 // mstatus
`define CSR_BIT_SW 3 // mie / mip
`define CSR_BIT_EXT 11 // mie / mip
`define CSR_BIT_INT 31 // mcause

// {interrupt flag, code} that retires a software interrupt
`define CSR_CAUSE_SW_INT 5'b10011

`define CSR_IRQ_HANDLER_DEFAULT 32'h0000_0010

`endif

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // data word, also used for every csr read word
    typedef logic [31:0] xlen_t;

    // csr address, or {int flag, code} during an exception
    typedef logic [11:0] csr_addr_t;

    typedef logic [2:0] csr_op_t;

    // exception code field of mcause
    typedef logic [3:0] exc_code_t;

endpackage

`default_nettype wire

//--- hw/csr_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_ctrl_if;

    logic is_exception;
    logic is_mret;
    logic is_csr; // rw, rs or rc
    logic read_stage;

    logic sel_mstatus;
    logic sel_mie;
    logic sel_mepc;
    logic sel_mcause;
    logic sel_mip;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mip;
    logic wr_exception;
    logic wr_mret;

    logic op_valid;

    // new = set_mask | (keep_mask & old)
    csr_pkg::xlen_t set_mask;
    csr_pkg::xlen_t keep_mask;

    modport decoder (
        output is_exception, is_mret, is_csr, read_stage,
        output sel_mstatus, sel_mie, sel_mepc, sel_mcause, sel_mip,
        output wr_mstatus, wr_mie, wr_mepc, wr_mcause, wr_mip, wr_exception, wr_mret,
        output op_valid, set_mask, keep_mask
    );

    modport regs (
        input is_exception, is_mret, is_csr, read_stage,
        input sel_mstatus, sel_mie, sel_mepc, sel_mcause, sel_mip,
        input wr_mstatus, wr_mie, wr_mepc, wr_mcause, wr_mip, wr_exception, wr_mret,
        input op_valid, set_mask, keep_mask
    );

endinterface

`default_nettype wire

//--- hw/csr_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csr_decode (
    input wire csr_pkg::csr_op_t op,
    input wire logic write_stage,
    input wire csr_pkg::csr_addr_t addr,
    input wire csr_pkg::xlen_t write_data,
    csr_ctrl_if.decoder ctrl
);

    logic is_rw;
    logic is_rs;
    logic is_rc;
    logic is_nop;
    logic is_csr;
    logic addr_known;

    assign is_rw = (op == `CSR_OP_RW);
    assign is_rs = (op == `CSR_OP_RS);
    assign is_rc = (op == `CSR_OP_RC);
    assign is_nop = (op == `CSR_OP_NOP);
    assign is_csr = is_rw | is_rs | is_rc;

    assign ctrl.is_exception = (op == `CSR_OP_EXCEPTION);
    assign ctrl.is_mret = (op == `CSR_OP_MRET);
    assign ctrl.is_csr = is_csr;
    assign ctrl.read_stage = ~write_stage;

    // selects only fire for a csr op
    assign ctrl.sel_mstatus = is_csr & (addr == `CSR_ADDR_MSTATUS);
    assign ctrl.sel_mie = is_csr & (addr == `CSR_ADDR_MIE);
    assign ctrl.sel_mepc = is_csr & (addr == `CSR_ADDR_MEPC);
    assign ctrl.sel_mcause = is_csr & (addr == `CSR_ADDR_MCAUSE);
    assign ctrl.sel_mip = is_csr & (addr == `CSR_ADDR_MIP);

    assign addr_known = ctrl.sel_mstatus | ctrl.sel_mie | ctrl.sel_mepc
                      | ctrl.sel_mcause | ctrl.sel_mip;

    assign ctrl.wr_mstatus = write_stage & ctrl.sel_mstatus;
    assign ctrl.wr_mie = write_stage & ctrl.sel_mie;
    assign ctrl.wr_mepc = write_stage & ctrl.sel_mepc;
    assign ctrl.wr_mcause = write_stage & ctrl.sel_mcause;
    assign ctrl.wr_mip = write_stage & ctrl.sel_mip;
    assign ctrl.wr_exception = write_stage & ctrl.is_exception;
    assign ctrl.wr_mret = write_stage & ctrl.is_mret;

    assign ctrl.op_valid = ctrl.is_exception | ctrl.is_mret | is_nop | addr_known;

    // rw: set=data keep=0, rs: set=data keep=1, rc: set=0 keep=~data
    always_comb begin
        ctrl.set_mask = is_rc ? '0 : write_data;
        if (is_rw) begin
            ctrl.keep_mask = '0;
        end else if (is_rs) begin
            ctrl.keep_mask = '1;
        end else begin
            ctrl.keep_mask = ~write_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csr_trap_regs (
    input wire logic clk,
    input wire logic rst,
    input wire csr_pkg::csr_addr_t addr,
    input wire csr_pkg::xlen_t write_data,
    csr_ctrl_if.regs ctrl,
    output logic ints_enabled,
    output csr_pkg::xlen_t mstatus_word,
    output csr_pkg::xlen_t mepc_word,
    output csr_pkg::xlen_t mcause_word
);

    logic ie;
    logic pie;
    logic temp_ie; // carries the enable from read stage to write stage
    logic [31:2] mepc_hi;
    logic trap_is_int;
    csr_pkg::exc_code_t exc_code;

    logic ie_masked;
    logic pie_masked;
    logic [31:2] mepc_masked;
    logic trap_is_int_masked;
    csr_pkg::exc_code_t exc_code_masked;

    assign ie_masked = ctrl.set_mask[`CSR_BIT_IE] | (ctrl.keep_mask[`CSR_BIT_IE] & ie);
    assign pie_masked = ctrl.set_mask[`CSR_BIT_PIE] | (ctrl.keep_mask[`CSR_BIT_PIE] & pie);
    assign mepc_masked = ctrl.set_mask[31:2] | (ctrl.keep_mask[31:2] & mepc_hi);
    assign trap_is_int_masked = ctrl.set_mask[`CSR_BIT_INT]
                              | (ctrl.keep_mask[`CSR_BIT_INT] & trap_is_int);
    assign exc_code_masked = ctrl.set_mask[3:0] | (ctrl.keep_mask[3:0] & exc_code);

    always_ff @(posedge clk) begin
        if (rst) begin
            ie <= 1'b0;
            pie <= 1'b0;
            temp_ie <= 1'b0;
            mepc_hi <= '0;
            trap_is_int <= 1'b0;
            exc_code <= '0;
        end else begin
            if (ctrl.read_stage && ctrl.is_exception) begin
                temp_ie <= ie;
            end else if (ctrl.read_stage && ctrl.is_mret) begin
                temp_ie <= pie;
            end

            if (ctrl.wr_exception) begin
                ie <= 1'b0; // handler runs with interrupts off
                pie <= temp_ie;
                mepc_hi <= write_data[31:2];
                trap_is_int <= addr[4];
                exc_code <= addr[3:0];
            end

            if (ctrl.wr_mret) begin
                ie <= temp_ie;
            end

            if (ctrl.wr_mstatus) begin
                ie <= ie_masked;
                pie <= pie_masked;
            end
            if (ctrl.wr_mepc) begin
                mepc_hi <= mepc_masked;
            end
            if (ctrl.wr_mcause) begin
                trap_is_int <= trap_is_int_masked;
                exc_code <= exc_code_masked;
            end
        end
    end

    assign ints_enabled = ie;
    assign mepc_word = {mepc_hi, 2'b00};

    always_comb begin
        mstatus_word = '0;
        mstatus_word[`CSR_BIT_IE] = ie;
        mstatus_word[`CSR_BIT_PIE] = pie;
    end

    always_comb begin
        mcause_word = '0;
        mcause_word[`CSR_BIT_INT] = trap_is_int;
        mcause_word[3:0] = exc_code;
    end

endmodule

`default_nettype wire

//--- hw/csr_irq_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csr_irq_regs (
    input wire logic clk,
    input wire logic rst,
    input wire logic ext_int,
    input wire logic ints_enabled,
    input wire csr_pkg::csr_addr_t addr,
    csr_ctrl_if.regs ctrl,
    output csr_pkg::xlen_t mie_word,
    output csr_pkg::xlen_t mip_word,
    output logic ext_int_pending,
    output logic sw_int_pending
);

    logic mie_ext;
    logic mie_sw;
    logic mip_ext;
    logic mip_sw;
    logic sw_clear;

    // exception taken for a software interrupt
    assign sw_clear = ctrl.wr_exception && (addr[4:0] == `CSR_CAUSE_SW_INT);

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_ext <= 1'b0;
            mie_sw <= 1'b0;
        end else if (ctrl.wr_mie) begin
            mie_ext <= ctrl.set_mask[`CSR_BIT_EXT] | (ctrl.keep_mask[`CSR_BIT_EXT] & mie_ext);
            mie_sw <= ctrl.set_mask[`CSR_BIT_SW] | (ctrl.keep_mask[`CSR_BIT_SW] & mie_sw);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mip_ext <= 1'b0;
        end else if (ext_int) begin
            mip_ext <= 1'b1; // line wins over a mip write
        end else if (ctrl.wr_mip) begin
            mip_ext <= ctrl.set_mask[`CSR_BIT_EXT] | (ctrl.keep_mask[`CSR_BIT_EXT] & mip_ext);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mip_sw <= 1'b0;
        end else if (sw_clear) begin
            mip_sw <= 1'b0;
        end else if (ctrl.wr_mip) begin
            mip_sw <= ctrl.set_mask[`CSR_BIT_SW] | (ctrl.keep_mask[`CSR_BIT_SW] & mip_sw);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ext_int_pending <= 1'b0;
            sw_int_pending <= 1'b0;
        end else begin
            ext_int_pending <= mip_ext & mie_ext & ints_enabled;
            sw_int_pending <= mip_sw & mie_sw & ints_enabled;
        end
    end

    always_comb begin
        mie_word = '0;
        mie_word[`CSR_BIT_EXT] = mie_ext;
        mie_word[`CSR_BIT_SW] = mie_sw;
    end

    always_comb begin
        mip_word = '0;
        mip_word[`CSR_BIT_EXT] = mip_ext;
        mip_word[`CSR_BIT_SW] = mip_sw;
    end

endmodule

`default_nettype wire

//--- hw/csr_read_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csr_read_port #(
    parameter csr_pkg::xlen_t irq_handler_addr = `CSR_IRQ_HANDLER_DEFAULT
) (
    input wire logic clk,
    input wire logic rst,
    input wire csr_pkg::xlen_t mstatus_word,
    input wire csr_pkg::xlen_t mie_word,
    input wire csr_pkg::xlen_t mepc_word,
    input wire csr_pkg::xlen_t mcause_word,
    input wire csr_pkg::xlen_t mip_word,
    csr_ctrl_if.regs ctrl,
    output csr_pkg::xlen_t read_value,
    output logic fault
);

    csr_pkg::xlen_t csr_word;
    csr_pkg::xlen_t next_value;
    logic load;

    // selects are one-hot, so an and-or mux is enough
    assign csr_word = ({32{ctrl.sel_mstatus}} & mstatus_word)
                    | ({32{ctrl.sel_mie}} & mie_word)
                    | ({32{ctrl.sel_mepc}} & mepc_word)
                    | ({32{ctrl.sel_mcause}} & mcause_word)
                    | ({32{ctrl.sel_mip}} & mip_word);

    always_comb begin
        if (ctrl.is_exception) begin
            next_value = irq_handler_addr;
        end else if (ctrl.is_mret) begin
            next_value = mepc_word;
        end else begin
            next_value = csr_word;
        end
    end

    assign load = ctrl.read_stage
                & (ctrl.is_exception | ctrl.is_mret | (ctrl.is_csr & ctrl.op_valid));

    always_ff @(posedge clk) begin
        if (rst) begin
            read_value <= '0;
            fault <= 1'b0;
        end else begin
            if (load) begin
                read_value <= next_value;
            end
            fault <= ~ctrl.op_valid; // every stage, valid or not
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csr_unit #(
    parameter csr_pkg::xlen_t irq_handler_addr = `CSR_IRQ_HANDLER_DEFAULT
) (
    input wire logic clk,
    input wire logic rst,
    input wire csr_pkg::csr_op_t op,
    input wire logic write_stage,
    input wire csr_pkg::csr_addr_t addr,
    input wire csr_pkg::xlen_t write_data,
    input wire logic ext_int,
    output csr_pkg::xlen_t read_value,
    output logic ext_int_pending,
    output logic sw_int_pending,
    output logic fault
);

    csr_ctrl_if ctrl ();

    logic ints_enabled;
    csr_pkg::xlen_t mstatus_word;
    csr_pkg::xlen_t mepc_word;
    csr_pkg::xlen_t mcause_word;
    csr_pkg::xlen_t mie_word;
    csr_pkg::xlen_t mip_word;

    csr_decode decode_i (
        .op(op),
        .write_stage(write_stage),
        .addr(addr),
        .write_data(write_data),
        .ctrl(ctrl.decoder)
    );

    csr_trap_regs trap_regs_i (
        .clk(clk),
        .rst(rst),
        .addr(addr),
        .write_data(write_data),
        .ctrl(ctrl.regs),
        .ints_enabled(ints_enabled),
        .mstatus_word(mstatus_word),
        .mepc_word(mepc_word),
        .mcause_word(mcause_word)
    );

    csr_irq_regs irq_regs_i (
        .clk(clk),
        .rst(rst),
        .ext_int(ext_int),
        .ints_enabled(ints_enabled),
        .addr(addr),
        .ctrl(ctrl.regs),
        .mie_word(mie_word),
        .mip_word(mip_word),
        .ext_int_pending(ext_int_pending),
        .sw_int_pending(sw_int_pending)
    );

    csr_read_port #(
        .irq_handler_addr(irq_handler_addr)
    ) read_port_i (
        .clk(clk),
        .rst(rst),
        .mstatus_word(mstatus_word),
        .mie_word(mie_word),
        .mepc_word(mepc_word),
        .mcause_word(mcause_word),
        .mip_word(mip_word),
        .ctrl(ctrl.regs),
        .read_value(read_value),
        .fault(fault)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // held for three rising edges, released on an edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/csr_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csr_unit_checker (
    input wire logic clk,
    input wire logic rst,
    input wire csr_pkg::csr_op_t op,
    input wire csr_pkg::csr_addr_t addr,
    input wire logic ext_int,
    input wire csr_pkg::xlen_t mip_word,
    input wire csr_pkg::xlen_t read_value,
    input wire logic ext_int_pending,
    input wire logic sw_int_pending,
    input wire logic fault
);

    int failures;
    logic addr_known;
    logic op_valid;

    initial failures = 0;

    assign addr_known = addr inside {`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MEPC,
                                     `CSR_ADDR_MCAUSE, `CSR_ADDR_MIP};
    assign op_valid = (op inside {`CSR_OP_EXCEPTION, `CSR_OP_MRET, `CSR_OP_NOP})
                    || ((op inside {`CSR_OP_RW, `CSR_OP_RS, `CSR_OP_RC}) && addr_known);

    reset_clears: assert property (@(posedge clk) $past(rst) |->
        (!fault && read_value == '0 && !ext_int_pending && !sw_int_pending))
        else begin
            failures++;
            $error("outputs not cleared by reset");
        end

    // fault lags the stage it describes by one cycle
    fault_tracks_validity: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (fault == !$past(op_valid)))
        else begin
            failures++;
            $error("fault does not match validity of the previous stage");
        end

    ext_sets_mip: assert property (@(posedge clk) disable iff (rst)
        ($past(ext_int) && !$past(rst)) |-> mip_word[`CSR_BIT_EXT])
        else begin
            failures++;
            $error("ext_int did not set the mip external bit");
        end

endmodule

bind csr_unit csr_unit_checker checker_i (
    .clk(clk),
    .rst(rst),
    .op(op),
    .addr(addr),
    .ext_int(ext_int),
    .mip_word(mip_word),
    .read_value(read_value),
    .ext_int_pending(ext_int_pending),
    .sw_int_pending(sw_int_pending),
    .fault(fault)
);

`default_nettype wire

//--- verification/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "csr_consts.svh"

module csr_unit_tb;

    typedef struct {
        string name;
        csr_pkg::csr_op_t op;
        logic ws;
        csr_pkg::csr_addr_t addr;
        csr_pkg::xlen_t data;
        logic ext;
        logic chk; // read_value checked after this stage
        csr_pkg::xlen_t rd;
        logic flt;
    } row_t;

    // word-aligned and away from the default
    localparam csr_pkg::xlen_t handler_addr = 32'h0000_0240;

    logic clk;
    logic rst;
    csr_pkg::csr_op_t op;
    logic write_stage;
    csr_pkg::csr_addr_t addr;
    csr_pkg::xlen_t write_data;
    logic ext_int;
    csr_pkg::xlen_t read_value;
    logic ext_int_pending;
    logic sw_int_pending;
    logic fault;

    row_t rows[$];
    int cycle_limit;
    int cycles;
    // model state for the pending outputs
    csr_pkg::xlen_t m_status;
    csr_pkg::xlen_t m_mie;
    csr_pkg::xlen_t m_mip;
    logic m_tmp;

    tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

    csr_unit #(
        .irq_handler_addr(handler_addr)
    ) csr_unit_i (.*);

    // rw/rs/rc on a whole word then cut to the implemented bits
    function automatic csr_pkg::xlen_t csr_apply(csr_pkg::csr_op_t o, csr_pkg::xlen_t old,
                                                 csr_pkg::xlen_t d, csr_pkg::xlen_t impl);
        case (o)
            `CSR_OP_RW: return d & impl;
            `CSR_OP_RS: return (old | d) & impl;
            default: return old & ~d & impl;
        endcase
    endfunction

    task automatic add_row(string name, csr_pkg::csr_op_t o, logic ws, csr_pkg::csr_addr_t a,
                           csr_pkg::xlen_t d, logic e, logic chk, csr_pkg::xlen_t rd, logic flt);
        row_t r;
        r = '{name, o, ws, a, d, e, chk, rd, flt};
        rows.push_back(r);
    endtask

    task automatic add_instr(string name, csr_pkg::csr_op_t o, csr_pkg::csr_addr_t a,
                             csr_pkg::xlen_t d, logic chk, csr_pkg::xlen_t rd, logic flt);
        add_row(name, o, 1'b0, a, d, 1'b0, chk, rd, flt);
        add_row(name, o, 1'b1, a, d, 1'b0, 1'b0, '0, flt);
    endtask

    task automatic build_table();
        csr_pkg::csr_addr_t regs[4];
        csr_pkg::xlen_t impl[4];
        csr_pkg::xlen_t v;
        regs = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE};
        impl = '{32'h0000_0088, 32'h0000_0808, 32'hFFFF_FFFC, 32'h8000_000F};
        foreach (regs[i])
            add_instr("reset read", `CSR_OP_RS, regs[i], '0, 1'b1, '0, 1'b0);
        add_instr("reset read", `CSR_OP_RS, `CSR_ADDR_MIP, '0, 1'b1, '0, 1'b0);
        foreach (regs[i]) begin
            add_instr($sformatf("rw %h", regs[i]), `CSR_OP_RW, regs[i], 32'h1234_5679,
                      1'b1, '0, 1'b0);
            v = csr_apply(`CSR_OP_RW, '0, 32'h1234_5679, impl[i]);
            add_instr($sformatf("rs %h", regs[i]), `CSR_OP_RS, regs[i], 32'h8000_0880,
                      1'b1, v, 1'b0);
            v = csr_apply(`CSR_OP_RS, v, 32'h8000_0880, impl[i]);
            add_instr($sformatf("rc %h", regs[i]), `CSR_OP_RC, regs[i], 32'h9, 1'b1, v, 1'b0);
            v = csr_apply(`CSR_OP_RC, v, 32'h9, impl[i]);
            add_instr($sformatf("read %h", regs[i]), `CSR_OP_RS, regs[i], '0, 1'b1, v, 1'b0);
        end
        add_instr("enable ie", `CSR_OP_RW, `CSR_ADDR_MSTATUS, 32'h8, 1'b0, '0, 1'b0);
        add_instr("exception", `CSR_OP_EXCEPTION, 12'h00B, 32'h1236, 1'b1,
                  handler_addr, 1'b0);
        add_instr("saved pc", `CSR_OP_RS, `CSR_ADDR_MEPC, '0, 1'b1, 32'h1234, 1'b0);
        add_instr("saved cause", `CSR_OP_RS, `CSR_ADDR_MCAUSE, '0, 1'b1, 32'hB, 1'b0);
        add_instr("ie saved", `CSR_OP_RS, `CSR_ADDR_MSTATUS, '0, 1'b1, 32'h80, 1'b0);
        add_instr("mret", `CSR_OP_MRET, '0, '0, 1'b1, 32'h1234, 1'b0);
        add_instr("ie restored", `CSR_OP_RS, `CSR_ADDR_MSTATUS, '0, 1'b1, 32'h88, 1'b0);
        add_instr("unknown csr", `CSR_OP_RW, 12'h305, '1, 1'b0, '0, 1'b1);
        add_instr("op 2", 3'd2, `CSR_ADDR_MSTATUS, '0, 1'b0, '0, 1'b1);
        add_instr("op 4", 3'd4, `CSR_ADDR_MSTATUS, '0, 1'b0, '0, 1'b1);
        add_instr("nop", `CSR_OP_NOP, '0, '0, 1'b0, '0, 1'b0);
        add_instr("enable irqs", `CSR_OP_RW, `CSR_ADDR_MIE, 32'h808, 1'b0, '0, 1'b0);
        add_row("ext pulse", `CSR_OP_NOP, 1'b0, '0, '0, 1'b1, 1'b0, '0, 1'b0);
        repeat (3)
            add_row("ext held", `CSR_OP_NOP, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
        add_instr("sw set", `CSR_OP_RS, `CSR_ADDR_MIP, 32'h8, 1'b1, 32'h800, 1'b0);
        repeat (3)
            add_row("sw held", `CSR_OP_NOP, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
        add_instr("sw exception", `CSR_OP_EXCEPTION, 12'h013, 32'h2000, 1'b1,
                  handler_addr, 1'b0);
        add_instr("sw cleared", `CSR_OP_RS, `CSR_ADDR_MIP, '0, 1'b1, 32'h800, 1'b0);
        repeat (2)
            add_row("ie off", `CSR_OP_NOP, 1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic update_model(row_t r);
        logic csr_wr;
        csr_wr = r.ws && (r.op >= `CSR_OP_RW);
        if (r.op == `CSR_OP_EXCEPTION && !r.ws) begin
            m_tmp = m_status[`CSR_BIT_IE];
        end else if (r.op == `CSR_OP_MRET && !r.ws) begin
            m_tmp = m_status[`CSR_BIT_PIE];
        end else if (r.op == `CSR_OP_EXCEPTION) begin
            m_status = '0; // handler entered with ie off
            m_status[`CSR_BIT_PIE] = m_tmp;
            if (r.addr[4:0] == `CSR_CAUSE_SW_INT) begin
                m_mip[`CSR_BIT_SW] = 1'b0;
            end
        end else if (r.op == `CSR_OP_MRET) begin
            m_status[`CSR_BIT_IE] = m_tmp;
        end else if (csr_wr && r.addr == `CSR_ADDR_MSTATUS) begin
            m_status = csr_apply(r.op, m_status, r.data, 32'h88);
        end else if (csr_wr && r.addr == `CSR_ADDR_MIE) begin
            m_mie = csr_apply(r.op, m_mie, r.data, 32'h808);
        end else if (csr_wr && r.addr == `CSR_ADDR_MIP) begin
            m_mip = csr_apply(r.op, m_mip, r.data, 32'h808);
        end
        if (r.ext) begin
            m_mip[`CSR_BIT_EXT] = 1'b1;
        end
    endtask

    task automatic check_value(string name, csr_pkg::xlen_t expected, csr_pkg::xlen_t actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // pending outputs lag the model state by one stage
    task automatic check_row(row_t r);
        logic exp_ext;
        logic exp_sw;
        exp_ext = m_mip[`CSR_BIT_EXT] & m_mie[`CSR_BIT_EXT] & m_status[`CSR_BIT_IE];
        exp_sw = m_mip[`CSR_BIT_SW] & m_mie[`CSR_BIT_SW] & m_status[`CSR_BIT_IE];
        update_model(r);
        if (r.chk) begin
            check_value({r.name, " read_value"}, r.rd, read_value);
        end
        check_value({r.name, " fault"}, 32'(r.flt), 32'(fault));
        check_value({r.name, " ext_int_pending"}, 32'(exp_ext), 32'(ext_int_pending));
        check_value({r.name, " sw_int_pending"}, 32'(exp_sw), 32'(sw_int_pending));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end else if (csr_unit_i.checker_i.failures != 0) begin
            $display("an assertion in the bound checker failed");
            $display(">>> FAIL");
            $fatal(1, "stopped at the first assertion failure");
        end
    end

    initial begin
        op = `CSR_OP_NOP;
        write_stage = 1'b0;
        addr = '0;
        write_data = '0;
        ext_int = 1'b0;
        m_status = '0;
        m_mie = '0;
        m_mip = '0;
        m_tmp = 1'b0;
        build_table();
        cycle_limit = rows.size() * 4 + 20;
        wait (rst === 1'b0);
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            if (i < rows.size()) begin
                op <= rows[i].op;
                write_stage <= rows[i].ws;
                addr <= rows[i].addr;
                write_data <= rows[i].data;
                ext_int <= rows[i].ext;
            end else begin
                op <= `CSR_OP_NOP;
                ext_int <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                check_row(rows[i - 1]);
            end
        end
        if (csr_unit_i.checker_i.failures != 0) begin
            $display(">>> FAIL");
            $fatal(1, "assertions failed in the bound checker");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- csr_unit.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_ctrl_if.sv
hw/csr_decode.sv
hw/csr_trap_regs.sv
hw/csr_irq_regs.sv
hw/csr_read_port.sv
hw/csr_unit.sv
verification/tb_clock_gen.sv
verification/csr_unit_checker.sv
verification/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/csr_pkg.sv
      - hw/csr_ctrl_if.sv
      - hw/csr_decode.sv
      - hw/csr_trap_regs.sv
      - hw/csr_irq_regs.sv
      - hw/csr_read_port.sv
      - hw/csr_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_clock_gen.sv
      - verification/csr_unit_checker.sv
      - verification/csr_unit_tb.sv
